//--- Makefile
.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f filelist.f --top-module fetch_tb \
		--Mdir obj_dir -o fetch_tb_sim

run: build
	./obj_dir/fetch_tb_sim | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log || (echo "simulation ended without a result"; exit 1)

lint:
	verilator --lint-only -Wall --timing -f filelist.f --top-module fetch_tb

clean:
	rm -rf obj_dir sim.log

//--- filelist.f
+incdir+verilog
verilog/fetch_pkg.sv
verilog/pre_decode.sv
verilog/if_stage.sv
verilog/inst_sram.sv
verilog/fetch_top.sv
sim/fetch_tb.sv

//--- sim/fetch_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "fetch_params.svh"

module fetch_tb;
    import fetch_pkg::*;

    // load is about 530 cycles, then roughly 200 handovers
    localparam int CYCLE_LIMIT = 4000;

    logic                     clk;
    logic                     reset;
    logic                     psel;
    logic                     penable;
    logic                     pwrite;
    logic [`FETCH_APB_AW-1:0] paddr;
    logic [31:0]              pwdata;
    logic                     pready;
    logic                     ds_allowin;
    br_bus_t                  br_bus;
    logic                     eret;
    logic [31:0]              cp0_epc;
    logic [3:0]               ex_word;
    logic                     fs_to_ds_valid;
    fs_to_ds_t                fs_bus;
    logic                     fs_is_branch;

    logic [31:0] shadow [`FETCH_IMEM_WORDS];
    logic [31:0] rng;
    logic [31:0] exp_pc;
    logic [31:0] pend_pc;
    logic        pend_valid;
    logic        allow_random;
    fs_to_ds_t   want;
    int          handovers;
    int          branch_seen;
    int          cycle_count;

    fetch_top i_fetch_top (
        .clk            (clk),
        .reset          (reset),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .pready         (pready),
        .ds_allowin     (ds_allowin),
        .br_bus         (br_bus),
        .eret           (eret),
        .cp0_epc        (cp0_epc),
        .ex_word        (ex_word),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_bus),
        .fs_is_branch   (fs_is_branch)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // expected IF-to-ID payload for a fetch at pc
    function automatic fs_to_ds_t exp_fetch(input logic [31:0] pc);
        fs_to_ds_t r;
        r.pc   = pc;
        r.inst = shadow[pc[9:2]];
        if (pc[1:0] != 2'b00) begin
            r.pc_error = 1'b1;
            r.badvaddr = pc;
            r.exc      = EXC_ADEL;
        end else begin
            r.pc_error = 1'b0;
            r.badvaddr = 32'd0;
            r.exc      = EXC_NONE;
        end
        return r;
    endfunction

    // branches and jumps by opcode, plus jr/jalr and the regimm branches
    function automatic logic branch_word(input logic [31:0] w);
        logic [5:0] op;
        logic [4:0] rt;
        logic [5:0] fn;
        op = w[31:26];
        rt = w[20:16];
        fn = w[5:0];
        case (op)
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_J, OP_JAL: return 1'b1;
            OP_REGIMM: return rt == 5'd0 || rt == 5'd1 || rt == 5'd16 || rt == 5'd17;
            OP_SPECIAL: return fn == 6'h08 || fn == 6'h09;
            default: return 1'b0;
        endcase
    endfunction

    task automatic fail_run();
        $display("TESTS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %h expected %h", $time, name, got, exp);
            fail_run();
        end
    endtask

    task automatic apb_write(input logic [`FETCH_APB_AW-1:0] a, input logic [31:0] d);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = a;
        pwdata  = d;
        @(posedge clk);
        #2 penable = 1'b1;
        check_value("pready", {31'd0, pready}, 32'd1);
        @(posedge clk);
        #2 psel = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // every eighth word is a beq
    task automatic load_program();
        logic [31:0] w;
        for (int i = 0; i < `FETCH_IMEM_WORDS; i++) begin
            rng = lcg_step(rng);
            w   = rng;
            if (i % 8 == 7) begin
                w = {OP_BEQ, rng[25:0]};
            end
            shadow[i] = w;
            apb_write({i[7:0], 2'b00}, w);
        end
    endtask

    task automatic wait_handovers(input int n);
        int goal;
        goal = handovers + n;
        while (handovers < goal) begin
            @(negedge clk);
        end
    endtask

    // stall until the bus is idle, then a one-cycle taken branch
    task automatic take_branch(input logic [31:0] target);
        @(posedge clk);
        #2 br_bus.stall = 1'b1;
        do begin
            @(negedge clk);
        end while (fs_to_ds_valid);
        @(posedge clk);
        #2 br_bus.stall = 1'b0;
        br_bus.br     = 1'b1;
        br_bus.taken  = 1'b1;
        br_bus.target = target;
        pend_pc       = target;
        pend_valid    = 1'b1;
        @(posedge clk);
        #2 br_bus.br = 1'b0;
        br_bus.taken = 1'b0;
    endtask

    // one-cycle writeback exception or eret, fired mid-stream
    task automatic pulse_redirect(input logic is_eret, input logic [31:0] epc);
        @(posedge clk);
        #2;
        if (is_eret) begin
            eret       = 1'b1;
            cp0_epc    = epc;
            pend_pc    = epc;
        end else begin
            ex_word    = 4'b0001;
            pend_pc    = `FETCH_EXC_VECTOR;
        end
        pend_valid = 1'b1;
        @(posedge clk);
        #2 eret = 1'b0;
        ex_word = 4'b0000;
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // decode model: random back-pressure when enabled
    always @(posedge clk) begin
        #2;
        if (allow_random) begin
            rng        = lcg_step(rng);
            ds_allowin = rng[31:30] != 2'b00;
        end else begin
            ds_allowin = 1'b1;
        end
    end

    // a handover seen in the redirect cycle is the old stream, so retarget after it
    always @(negedge clk) begin
        if (!reset && fs_to_ds_valid && ds_allowin) begin
            want = exp_fetch(exp_pc);
            check_value("fs_to_ds_bus.pc", fs_bus.pc, want.pc);
            check_value("fs_to_ds_bus.inst", fs_bus.inst, want.inst);
            check_value("fs_to_ds_bus.exc", {27'd0, fs_bus.exc}, {27'd0, want.exc});
            check_value("fs_to_ds_bus.pc_error", {31'd0, fs_bus.pc_error},
                        {31'd0, want.pc_error});
            check_value("fs_to_ds_bus.badvaddr", fs_bus.badvaddr, want.badvaddr);
            check_value("fs_is_branch", {31'd0, fs_is_branch},
                        {31'd0, branch_word(want.inst)});
            if (fs_is_branch) begin
                branch_seen++;
            end
            handovers++;
            exp_pc = exp_pc + 32'd4;
        end else if (!reset && !fs_to_ds_valid) begin
            // no word on the bus, so nothing may look like a branch
            check_value("fs_is_branch", {31'd0, fs_is_branch}, 32'd0);
        end
        if (pend_valid) begin
            exp_pc     = pend_pc;
            pend_valid = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the fetch stream stopped before all scenarios finished");
            fail_run();
        end
    end

    initial begin
        reset        = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = 32'd0;
        ds_allowin   = 1'b1;
        br_bus       = '0;
        br_bus.stall = 1'b1;
        eret         = 1'b0;
        cp0_epc      = 32'd0;
        ex_word      = 4'b0000;
        rng          = 32'hf40d373e;
        exp_pc       = `FETCH_RESET_PC;
        pend_pc      = 32'd0;
        pend_valid   = 1'b0;
        allow_random = 1'b0;
        handovers    = 0;
        branch_seen  = 0;
        cycle_count  = 0;
        repeat (16) @(posedge clk);
        #2 reset = 1'b0;
        load_program();
        @(negedge clk);
        check_value("fs_to_ds_valid", {31'd0, fs_to_ds_valid}, 32'd0);
        @(posedge clk);
        #2 br_bus.stall = 1'b0;
        wait_handovers(32);
        allow_random = 1'b1;
        wait_handovers(100);
        allow_random = 1'b0;
        take_branch(32'hbfc0_0200);
        wait_handovers(12);
        take_branch(32'hbfc0_0040);
        wait_handovers(12);
        // misaligned target, wraps past the top word
        take_branch(32'hbfc0_03f2);
        wait_handovers(8);
        take_branch(32'hbfc0_0080);
        wait_handovers(8);
        pulse_redirect(1'b0, 32'd0);
        wait_handovers(12);
        pulse_redirect(1'b1, 32'hbfc0_0150);
        wait_handovers(12);
        if (branch_seen == 0) begin
            $display("no handed-over word was classified as a branch");
            fail_run();
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- verilog/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// first address fetched after reset
`define FETCH_RESET_PC   32'hbfc0_0000

// general exception entry point
`define FETCH_EXC_VECTOR 32'hbfc0_0380

// instruction memory depth in 32-bit words
// word index comes from address bits 9 to 2
`define FETCH_IMEM_WORDS 256

// apb byte address width, word aligned
`define FETCH_APB_AW     10

`endif

//--- verilog/fetch_pkg.sv
`default_nettype none

package fetch_pkg;

    // exception codes carried toward decode
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4
    } exc_code_t;

    // primary opcodes that matter to the fetch front end
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_REGIMM  = 6'h01,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_BLEZ    = 6'h06,
        OP_BGTZ    = 6'h07
    } mips_op_t;

    // branch info from decode, 35 bits
    typedef struct packed {
        logic        br;
        logic        stall;
        logic        taken;
        logic [31:0] target;
    } br_bus_t;

    // IF to ID payload, 102 bits
    typedef struct packed {
        logic        pc_error;
        logic [31:0] badvaddr;
        exc_code_t   exc;
        logic [31:0] inst;
        logic [31:0] pc;
    } fs_to_ds_t;

endpackage

`default_nettype wire

//--- verilog/fetch_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "fetch_params.svh"

module fetch_top (
    input  wire                        clk,
    input  wire                        reset,
    // apb program load
    input  wire                        psel,
    input  wire                        penable,
    input  wire                        pwrite,
    input  wire  [`FETCH_APB_AW-1:0]   paddr,
    input  wire  [31:0]                pwdata,
    output wire                        pready,
    // decode side
    input  wire                        ds_allowin,
    input  wire fetch_pkg::br_bus_t    br_bus,
    input  wire                        eret,
    input  wire  [31:0]                cp0_epc,
    input  wire  [3:0]                 ex_word,
    output wire                        fs_to_ds_valid,
    output wire fetch_pkg::fs_to_ds_t  fs_to_ds_bus,
    output wire                        fs_is_branch
);

    wire        sram_en;
    wire [31:0] sram_addr;
    wire        sram_addr_ok;
    wire        sram_data_ok;
    wire [31:0] sram_rdata;

    if_stage i_if_stage (
        .clk               (clk),
        .reset             (reset),
        .ds_allowin        (ds_allowin),
        .br_bus            (br_bus),
        .fs_to_ds_valid    (fs_to_ds_valid),
        .fs_to_ds_bus      (fs_to_ds_bus),
        .fs_is_branch      (fs_is_branch),
        .inst_sram_en      (sram_en),
        .inst_sram_addr    (sram_addr),
        .inst_sram_addr_ok (sram_addr_ok),
        .inst_sram_data_ok (sram_data_ok),
        .inst_sram_rdata   (sram_rdata),
        .eret              (eret),
        .cp0_epc           (cp0_epc),
        .ex_word           (ex_word)
    );

    inst_sram i_inst_sram (
        .clk     (clk),
        .reset   (reset),
        .en      (sram_en),
        .addr    (sram_addr),
        .addr_ok (sram_addr_ok),
        .data_ok (sram_data_ok),
        .rdata   (sram_rdata),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .pready  (pready)
    );

endmodule

`default_nettype wire

//--- verilog/if_stage.sv
`timescale 1ns/1ns
`default_nettype none
`include "fetch_params.svh"

module if_stage (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      ds_allowin,
    input  wire fetch_pkg::br_bus_t  br_bus,
    output logic                     fs_to_ds_valid,
    output fetch_pkg::fs_to_ds_t     fs_to_ds_bus,
    output logic                     fs_is_branch,
    output logic                     inst_sram_en,
    output logic [31:0]              inst_sram_addr,
    input  wire                      inst_sram_addr_ok,
    input  wire                      inst_sram_data_ok,
    input  wire  [31:0]              inst_sram_rdata,
    input  wire                      eret,
    input  wire  [31:0]              cp0_epc,
    input  wire  [3:0]               ex_word
);
    import fetch_pkg::*;

    logic        fs_valid;
    logic [31:0] fs_pc;
    logic        en_q;
    logic        redir_valid;
    logic [31:0] redir_pc;

    logic        ws_ex;
    logic        br_taken;
    logic        redirect;
    logic [31:0] redirect_pc;
    logic [31:0] seq_pc;
    logic [31:0] nextpc;
    logic        req_fire;
    logic        replay;
    logic        adel;
    logic [31:0] pre_inst;

    // redirect sources, highest priority first
    assign ws_ex    = ex_word[0];
    assign br_taken = br_bus.br && br_bus.taken && fs_valid;
    assign redirect = ws_ex || eret || br_taken;

    always_comb begin
        if (ws_ex) begin
            redirect_pc = `FETCH_EXC_VECTOR;
        end else if (eret) begin
            redirect_pc = cp0_epc;
        end else begin
            redirect_pc = br_bus.target;
        end
    end

    // pre-IF: a held redirect or replay wins over the sequential address
    assign seq_pc = fs_pc + 32'd4;
    assign nextpc = redirect    ? redirect_pc :
                    redir_valid ? redir_pc    :
                                  seq_pc;

    // one transaction at a time, nothing new while decode stalls
    assign inst_sram_en   = en_q && !br_bus.stall;
    assign inst_sram_addr = {nextpc[31:2], 2'b00};
    assign req_fire       = inst_sram_en && inst_sram_addr_ok;

    // refused word gets fetched again from the same pc
    assign replay = inst_sram_data_ok && !ds_allowin;

    always_ff @(posedge clk) begin
        if (reset) begin
            en_q <= 1'b1;
        end else if (req_fire) begin
            en_q <= 1'b0;
        end else if (inst_sram_data_ok) begin
            en_q <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (ws_ex || req_fire) begin
            fs_valid <= 1'b1;
        end
    end

    // starts one word below the reset pc so the first seq_pc is the reset pc
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_pc <= `FETCH_RESET_PC - 32'd4;
        end else if (req_fire) begin
            fs_pc <= nextpc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            redir_valid <= 1'b0;
        end else if (req_fire) begin
            redir_valid <= 1'b0;
        end else if (redirect || replay) begin
            redir_valid <= 1'b1;
        end
    end

    // a pending redirect is not overwritten by a replay of an older word
    always_ff @(posedge clk) begin
        if (redirect) begin
            redir_pc <= redirect_pc;
        end else if (replay && !redir_valid) begin
            redir_pc <= fs_pc;
        end
    end

    // IF stage output, valid only in the data_ok cycle
    assign fs_to_ds_valid = fs_valid && inst_sram_data_ok;

    // AdEL only when no later stage reports an exception
    assign adel = (ex_word == 4'b0000) && (fs_pc[1:0] != 2'b00);

    always_comb begin
        fs_to_ds_bus.pc_error = adel;
        fs_to_ds_bus.badvaddr = adel ? fs_pc : 32'd0;
        fs_to_ds_bus.exc      = adel ? EXC_ADEL : EXC_NONE;
        fs_to_ds_bus.inst     = inst_sram_rdata;
        fs_to_ds_bus.pc       = fs_pc;
    end

    // word outside data_ok reads as zero, i.e. not a branch
    assign pre_inst = inst_sram_rdata & {32{inst_sram_data_ok}};

    pre_decode i_pre_decode (
        .inst      (pre_inst),
        .is_branch (fs_is_branch)
    );

endmodule

`default_nettype wire

//--- verilog/inst_sram.sv
`timescale 1ns/1ns
`default_nettype none
`include "fetch_params.svh"

module inst_sram (
    input  wire                      clk,
    input  wire                      reset,
    // sram-like read port
    input  wire                      en,
    input  wire  [31:0]              addr,
    output logic                     addr_ok,
    output logic                     data_ok,
    output logic [31:0]              rdata,
    // apb write port for program load
    input  wire                      psel,
    input  wire                      penable,
    input  wire                      pwrite,
    input  wire  [`FETCH_APB_AW-1:0] paddr,
    input  wire  [31:0]              pwdata,
    output logic                     pready
);

    localparam int IDX_W = $clog2(`FETCH_IMEM_WORDS);

    logic [31:0]      mem [`FETCH_IMEM_WORDS];
    logic             pending;
    logic [31:0]      rdata_q;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             apb_write;

    // upper address bits are ignored
    assign rd_idx = addr[IDX_W+1:2];
    assign wr_idx = paddr[IDX_W+1:2];

    // accept only with nothing outstanding
    assign addr_ok = en && !pending;

    // data returns the cycle after the address is taken
    assign data_ok = pending;
    assign rdata   = rdata_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
        end else begin
            pending <= addr_ok;
        end
    end

    always_ff @(posedge clk) begin
        if (addr_ok) begin
            rdata_q <= mem[rd_idx];
        end
    end

    // apb access phase, zero wait states
    assign pready    = 1'b1;
    assign apb_write = psel && penable && pwrite;

    always_ff @(posedge clk) begin
        if (apb_write) begin
            mem[wr_idx] <= pwdata;
        end
    end

endmodule

`default_nettype wire

//--- verilog/pre_decode.sv
`timescale 1ns/1ns
`default_nettype none

module pre_decode (
    input  wire  [31:0] inst,
    output logic        is_branch
);
    import fetch_pkg::*;

    // function codes of register jumps
    localparam logic [5:0] FN_JR   = 6'b001000;
    localparam logic [5:0] FN_JALR = 6'b001001;

    mips_op_t   op;
    logic [4:0] rt;
    logic [5:0] funct;

    assign op    = mips_op_t'(inst[31:26]);
    assign rt    = inst[20:16];
    assign funct = inst[5:0];

    always_comb begin
        case (op)
            OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: is_branch = 1'b1;
            OP_J, OP_JAL: is_branch = 1'b1;
            // bltz, bgez, bltzal, bgezal
            OP_REGIMM: is_branch = (rt[3:1] == 3'b000);
            OP_SPECIAL: is_branch = (funct == FN_JR) || (funct == FN_JALR);
            default: is_branch = 1'b0;
        endcase
    end

endmodule

`default_nettype wire
